// ==== all.f ====
source/datapathPkg.sv
source/registerFile.sv
source/alu.sv
source/conditionFlags.sv
source/specialRegisters.sv
source/cpuDatapath.sv
tests/cpuDatapathTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the datapath testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuDatapathTb \
	-f all.f -o cpuDatapathSim

./obj_dir/cpuDatapathSim | tee sim.log

if grep -q "All checks passed" sim.log; then
	exit 0
else
	exit 1
fi

// ==== source/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu #(
	parameter int Width = datapathPkg::DataWidth
) (
	input datapathPkg::aluOpT op_i,
	input logic [Width-1:0] a_i,
	input logic [Width-1:0] b_i,
	output logic [Width-1:0] result_o,
	output datapathPkg::flagsT nextFlags_o
);
	import datapathPkg::*;

	logic arith;
	logic carryIn;
	logic [Width-1:0] bOperand;
	logic [Width:0] fullSum;
	logic [Width-1:0] lowSum;
	logic carryTop;
	logic carryBelowTop;
	logic [Width-1:0] result;

	assign arith = (op_i == aluAdd) || (op_i == aluSub);

	// Subtract is a plus not b plus one, on the same adder.
	assign carryIn = (op_i == aluSub);
	assign bOperand = carryIn ? ~b_i : b_i;

	assign fullSum = {1'b0, a_i} + {1'b0, bOperand} + {{Width{1'b0}}, carryIn};

	// The low bits are summed alone to recover the carry into the sign bit.
	assign lowSum = {1'b0, a_i[Width-2:0]} + {1'b0, bOperand[Width-2:0]}
		+ {{(Width-1){1'b0}}, carryIn};

	assign carryTop = arith & fullSum[Width]; // Logic operations carry nothing.
	assign carryBelowTop = arith & lowSum[Width-1];

	always_comb begin
		case (op_i)
			aluAdd, aluSub: begin
				result = fullSum[Width-1:0];
			end
			aluAnd: begin
				result = a_i & b_i;
			end
			aluOr: begin
				result = a_i | b_i;
			end
			aluXor: begin
				result = a_i ^ b_i;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign result_o = result;

	assign nextFlags_o.zero = (result == '0);
	assign nextFlags_o.carry = carryTop;
	assign nextFlags_o.overflow = carryTop ^ carryBelowTop; // Signed overflow.
	assign nextFlags_o.minus = result[Width-1];

	// The controller must never issue the retired duplicate subtract code.
	always_comb begin
		assert (op_i inside {aluAdd, aluSub, aluAnd, aluOr, aluXor})
			else $error("alu: undefined operation code %0d", op_i);
	end

endmodule

`default_nettype wire

// ==== source/conditionFlags.sv ====
`timescale 1ns/100ps
`default_nettype none

module conditionFlags (
	input logic Clock,
	input logic rstN_i,
	input logic flagsWrite_i,
	input datapathPkg::flagsT nextFlags_i,
	input datapathPkg::flagSelT jumpFlagSel_i,
	output datapathPkg::flagsT flags_o,
	output logic jumpTaken_o
);
	import datapathPkg::*;

	flagsT flagsQ;

	// All four flags share one write enable.
	always_ff @(posedge Clock or negedge rstN_i) begin
		if (!rstN_i) begin
			flagsQ <= '0;
		end else if (flagsWrite_i) begin
			flagsQ <= nextFlags_i;
		end
	end

	always_comb begin
		case (jumpFlagSel_i)
			selMinus: jumpTaken_o = flagsQ.minus;
			selZero: jumpTaken_o = flagsQ.zero;
			selOverflow: jumpTaken_o = flagsQ.overflow;
			default: jumpTaken_o = flagsQ.carry;
		endcase
	end

	assign flags_o = flagsQ;

	// Flags stay cleared past the first active cycle unless that cycle wrote them.
	assert property (@(posedge Clock)
		$rose(rstN_i) && !flagsWrite_i |=> flags_o == '0)
		else $error("conditionFlags: flags not clear after reset");

endmodule

`default_nettype wire

// ==== source/cpuDatapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuDatapath (
	input logic Clock,
	input logic rstN_i,
	input datapathPkg::controlWordT ctrl_i,
	input datapathPkg::dataT memReadData_i,
	output datapathPkg::dataT memAddr_o,
	output datapathPkg::dataT memWriteData_o,
	output datapathPkg::dataT ir_o,
	output datapathPkg::dataT pc_o,
	output datapathPkg::flagsT flags_o,
	output logic jumpTaken_o
);
	import datapathPkg::*;

	dataT bus;
	dataT tWord;
	dataT aluResult;
	dataT regReadData;
	dataT regWriteData;
	regNumT regNum;
	flagsT nextFlags;

	specialRegisters #(
		.Width(DataWidth)
	) specialRegisters_inst (
		.Clock(Clock),
		.rstN_i(rstN_i),
		.ctrl_i(ctrl_i),
		.memReadData_i(memReadData_i),
		.regReadData_i(regReadData),
		.aluResult_i(aluResult),
		.bus_o(bus),
		.t_o(tWord),
		.regNum_o(regNum),
		.regWriteData_o(regWriteData),
		.mar_o(memAddr_o),
		.mdr_o(memWriteData_o),
		.ir_o(ir_o),
		.pc_o(pc_o)
	);

	registerFile #(
		.Width(DataWidth)
	) registerFile_inst (
		.Clock(Clock),
		.rstN_i(rstN_i),
		.regNum_i(regNum),
		.regWrite_i(ctrl_i.regWrite),
		.writeData_i(regWriteData),
		.readData_o(regReadData)
	);

	// T is the left operand and the bus the right one.
	alu #(
		.Width(DataWidth)
	) alu_inst (
		.op_i(ctrl_i.aluOp),
		.a_i(tWord),
		.b_i(bus),
		.result_o(aluResult),
		.nextFlags_o(nextFlags)
	);

	conditionFlags conditionFlags_inst (
		.Clock(Clock),
		.rstN_i(rstN_i),
		.flagsWrite_i(ctrl_i.flagsWrite),
		.nextFlags_i(nextFlags),
		.jumpFlagSel_i(ctrl_i.jumpFlagSel),
		.flags_o(flags_o),
		.jumpTaken_o(jumpTaken_o)
	);

endmodule

`default_nettype wire

// ==== source/datapathPkg.sv ====
`default_nettype none

package datapathPkg;

	localparam int DataWidth = 16;
	localparam int RegNumWidth = 3; // Eight general registers.

	typedef logic [DataWidth-1:0] dataT;
	typedef logic [RegNumWidth-1:0] regNumT;

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluXor = 3'd4
	} aluOpT;

	// Sources that may drive the shared operand bus.
	typedef enum logic [2:0] {
		busMdr = 3'd0,
		busPc = 3'd1,
		busRegFile = 3'd2,
		busAluOut = 3'd3,
		busConst2 = 3'd4,
		busConst0 = 3'd5
	} busSrcT;

	// IR field that names the register file entry.
	typedef enum logic [1:0] {
		fieldA = 2'd0, // IR[11:9].
		fieldB = 2'd1, // IR[8:6].
		fieldC = 2'd2 // IR[5:3].
	} regNumSrcT;

	typedef enum logic [1:0] {
		selMinus = 2'd0,
		selZero = 2'd1,
		selOverflow = 2'd2,
		selCarry = 2'd3
	} flagSelT;

	typedef struct packed {
		logic zero;
		logic carry;
		logic overflow;
		logic minus;
	} flagsT;

	// One control word is applied by the controller every cycle.
	typedef struct packed {
		busSrcT busSrc;
		aluOpT aluOp;
		regNumSrcT regNumSrc;
		flagSelT jumpFlagSel;
		logic marWrite;
		logic mdrWrite;
		logic pcWrite;
		logic tWrite;
		logic irWrite;
		logic aluOutWrite;
		logic flagsWrite;
		logic regWrite;
		logic marFromAlu; // Else MAR loads from the bus.
		logic mdrFromAlu; // Else MDR loads from memory.
		logic regFromAlu; // Else the register file loads from the bus.
	} controlWordT;

endpackage

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

module registerFile #(
	parameter int Width = datapathPkg::DataWidth
) (
	input logic Clock,
	input logic rstN_i,
	input datapathPkg::regNumT regNum_i,
	input logic regWrite_i,
	input logic [Width-1:0] writeData_i,
	output logic [Width-1:0] readData_o
);
	import datapathPkg::*;

	localparam int RegCount = 2 ** RegNumWidth;

	logic [Width-1:0] regs [RegCount];
	logic [RegCount-1:0] writeSel;

	// One-hot write decode of the register number.
	assign writeSel = regWrite_i ? (RegCount'(1) << regNum_i) : '0;

	always_ff @(posedge Clock or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < RegCount; i++) begin
				if (writeSel[i]) begin
					regs[i] <= writeData_i;
				end
			end
		end
	end

	// Reads go straight onto the bus source within the cycle.
	assign readData_o = regs[regNum_i];

	// The register number comes from the IR through the special registers,
	// so an unknown IR field would corrupt some entry.
	assert property (@(posedge Clock) disable iff (!rstN_i)
		regWrite_i |-> !$isunknown(regNum_i))
		else $error("registerFile: write with unknown register number");

endmodule

`default_nettype wire

// ==== source/specialRegisters.sv ====
`timescale 1ns/100ps
`default_nettype none

module specialRegisters #(
	parameter int Width = datapathPkg::DataWidth
) (
	input logic Clock,
	input logic rstN_i,
	input datapathPkg::controlWordT ctrl_i,
	input logic [Width-1:0] memReadData_i,
	input logic [Width-1:0] regReadData_i,
	input logic [Width-1:0] aluResult_i,
	output logic [Width-1:0] bus_o,
	output logic [Width-1:0] t_o,
	output datapathPkg::regNumT regNum_o,
	output logic [Width-1:0] regWriteData_o,
	output logic [Width-1:0] mar_o,
	output logic [Width-1:0] mdr_o,
	output logic [Width-1:0] ir_o,
	output logic [Width-1:0] pc_o
);
	import datapathPkg::*;

	logic [Width-1:0] marQ;
	logic [Width-1:0] mdrQ;
	logic [Width-1:0] pcQ;
	logic [Width-1:0] tQ;
	logic [Width-1:0] irQ;
	logic [Width-1:0] aluOutQ;
	logic [Width-1:0] busWord;
	logic [Width-1:0] marNext;
	logic [Width-1:0] mdrNext;

	// One source at a time drives the operand bus.
	always_comb begin
		case (ctrl_i.busSrc)
			busMdr: busWord = mdrQ;
			busPc: busWord = pcQ;
			busRegFile: busWord = regReadData_i;
			busAluOut: busWord = aluOutQ;
			busConst2: busWord = Width'(2);
			default: busWord = '0;
		endcase
	end

	always_comb begin
		case (ctrl_i.regNumSrc)
			fieldA: regNum_o = irQ[11:9];
			fieldB: regNum_o = irQ[8:6];
			fieldC: regNum_o = irQ[5:3];
			default: regNum_o = '0;
		endcase
	end

	assign marNext = ctrl_i.marFromAlu ? aluResult_i : busWord;
	assign mdrNext = ctrl_i.mdrFromAlu ? aluResult_i : memReadData_i;
	assign regWriteData_o = ctrl_i.regFromAlu ? aluResult_i : busWord;

	always_ff @(posedge Clock or negedge rstN_i) begin
		if (!rstN_i) begin
			marQ <= '0;
			mdrQ <= '0;
			pcQ <= '0;
			tQ <= '0;
			irQ <= '0;
			aluOutQ <= '0;
		end else begin
			if (ctrl_i.marWrite) begin
				marQ <= marNext;
			end
			if (ctrl_i.mdrWrite) begin
				mdrQ <= mdrNext;
			end
			if (ctrl_i.pcWrite) begin
				pcQ <= aluResult_i; // PC always steps through the ALU.
			end
			if (ctrl_i.tWrite) begin
				tQ <= busWord;
			end
			if (ctrl_i.irWrite) begin
				irQ <= mdrQ; // Instruction fetch goes through MDR.
			end
			if (ctrl_i.aluOutWrite) begin
				aluOutQ <= aluResult_i;
			end
		end
	end

	assign bus_o = busWord;
	assign t_o = tQ;
	assign mar_o = marQ;
	assign mdr_o = mdrQ;
	assign ir_o = irQ;
	assign pc_o = pcQ;

	// The controller never leaves the bus undriven once out of reset.
	assert property (@(posedge Clock) disable iff (!rstN_i)
		ctrl_i.busSrc inside {busMdr, busPc, busRegFile, busAluOut, busConst2, busConst0})
		else $error("specialRegisters: undefined bus source %0d", ctrl_i.busSrc);

endmodule

`default_nettype wire

// ==== tests/cpuDatapathTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuDatapathTb;
	import datapathPkg::*;

	logic Clock;
	logic rstN_i;
	controlWordT ctrl_i;
	dataT memReadData_i;
	dataT memAddr_o;
	dataT memWriteData_o;
	dataT ir_o;
	dataT pc_o;
	flagsT flags_o;
	logic jumpTaken_o;

	int errors = 0;
	int checks = 0;
	logic [31:0] lfsr = 32'h9b1c;

	// Expected state that the model tracks.
	dataT mRegs [8];
	dataT mMar;
	dataT mMdr;
	dataT mPc;
	dataT mT;
	dataT mIr;
	dataT mAluOut;
	flagsT mFlags;

	cpuDatapath cpuDatapath_inst (
		.Clock(Clock),
		.rstN_i(rstN_i),
		.ctrl_i(ctrl_i),
		.memReadData_i(memReadData_i),
		.memAddr_o(memAddr_o),
		.memWriteData_o(memWriteData_o),
		.ir_o(ir_o),
		.pc_o(pc_o),
		.flags_o(flags_o),
		.jumpTaken_o(jumpTaken_o)
	);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	initial begin
		#100000;
		$display("Timeout: the run did not finish in time");
		$display("Checks failed");
		$finish;
	end

	// The model is updated on the falling edge, so both sides are settled at the rising one.
	assert property (@(posedge Clock) disable iff (!rstN_i)
		{memAddr_o, memWriteData_o, ir_o, pc_o, flags_o} == {mMar, mMdr, mIr, mPc, mFlags})
		else begin
			errors++;
			$display("Mismatch cycle state expected %h actual %h",
				$sampled({mMar, mMdr, mIr, mPc, mFlags}),
				$sampled({memAddr_o, memWriteData_o, ir_o, pc_o, flags_o}));
		end

	// Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken.
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic dataT aluModel(input aluOpT op, input dataT a, input dataT b,
		output flagsT f);
		logic [16:0] s;
		dataT bb;
		dataT r;
		logic c14;
		bb = (op == aluSub) ? ~b : b;
		s = {1'b0, a} + {1'b0, bb} + ((op == aluSub) ? 17'd1 : 17'd0);
		case (op)
			aluAnd: r = a & b;
			aluOr: r = a | b;
			aluXor: r = a ^ b;
			default: r = s[15:0];
		endcase
		c14 = s[15] ^ a[15] ^ bb[15]; // Carry into the sign bit.
		f.carry = (op == aluAdd || op == aluSub) ? s[16] : 1'b0;
		f.overflow = (op == aluAdd || op == aluSub) ? (s[16] ^ c14) : 1'b0;
		f.zero = (r == 16'd0);
		f.minus = r[15];
		return r;
	endfunction

	function automatic controlWordT idleWord();
		controlWordT c;
		c = '0;
		c.busSrc = busConst0;
		return c;
	endfunction

	task automatic checkValue(input string name, input dataT exp, input dataT act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("Mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic checkState(input string name);
		checkValue({name, " mar"}, mMar, memAddr_o);
		checkValue({name, " mdr"}, mMdr, memWriteData_o);
		checkValue({name, " ir"}, mIr, ir_o);
		checkValue({name, " pc"}, mPc, pc_o);
		checkValue({name, " flags"}, dataT'(mFlags), dataT'(flags_o));
	endtask

	// Drives one control word for one cycle and updates the expected state.
	task automatic applyWord(input controlWordT c, input dataT mem);
		dataT bus;
		dataT res;
		flagsT nf;
		regNumT rn;
		ctrl_i = c;
		memReadData_i = mem;
		case (c.busSrc)
			busMdr: bus = mMdr;
			busPc: bus = mPc;
			busAluOut: bus = mAluOut;
			busConst2: bus = 16'd2;
			default: bus = 16'd0;
		endcase
		case (c.regNumSrc)
			fieldA: rn = mIr[11:9];
			fieldB: rn = mIr[8:6];
			default: rn = mIr[5:3];
		endcase
		if (c.busSrc == busRegFile) bus = mRegs[rn];
		res = aluModel(c.aluOp, mT, bus, nf);
		@(negedge Clock);
		if (c.regWrite) mRegs[rn] = c.regFromAlu ? res : bus;
		if (c.marWrite) mMar = c.marFromAlu ? res : bus;
		if (c.pcWrite) mPc = res;
		if (c.tWrite) mT = bus;
		if (c.irWrite) mIr = mMdr; // Uses MDR before this cycle's load.
		if (c.mdrWrite) mMdr = c.mdrFromAlu ? res : mem;
		if (c.aluOutWrite) mAluOut = res;
		if (c.flagsWrite) mFlags = nf;
	endtask

	task automatic loadMdr(input dataT w);
		controlWordT c;
		c = idleWord();
		c.mdrWrite = 1'b1;
		applyWord(c, w);
	endtask

	task automatic loadIr(input dataT w);
		controlWordT c;
		loadMdr(w);
		c = idleWord();
		c.irWrite = 1'b1;
		applyWord(c, 16'd0);
	endtask

	// Writes a word into the register that IR field A names.
	task automatic writeReg(input regNumT r, input dataT w);
		controlWordT c;
		loadIr(dataT'(r) << 9);
		loadMdr(w);
		c = idleWord();
		c.busSrc = busMdr;
		c.regNumSrc = fieldA;
		c.regWrite = 1'b1;
		applyWord(c, 16'd0);
	endtask

	task automatic checkJumps(input string name);
		controlWordT c;
		logic [3:0] want;
		want = {mFlags.minus, mFlags.zero, mFlags.overflow, mFlags.carry};
		for (int s = 0; s < 4; s++) begin
			c = idleWord();
			c.jumpFlagSel = flagSelT'(s);
			ctrl_i = c;
			#1;
			checkValue({name, " jump"}, dataT'(want[3-s]), dataT'(jumpTaken_o));
			@(negedge Clock);
		end
	endtask

	task automatic runAlu(input aluOpT op, input dataT a, input dataT b);
		controlWordT c;
		dataT want;
		flagsT f;
		loadMdr(a);
		c = idleWord();
		c.busSrc = busMdr;
		c.tWrite = 1'b1;
		applyWord(c, 16'd0);
		loadMdr(b);
		want = aluModel(op, a, b, f);
		c = idleWord();
		c.busSrc = busMdr;
		c.aluOp = op;
		c.marWrite = 1'b1;
		c.marFromAlu = 1'b1;
		c.flagsWrite = 1'b1;
		applyWord(c, 16'd0);
		checkValue("alu result", want, memAddr_o);
		checkValue("alu flags", dataT'(f), dataT'(flags_o));
		checkState("alu");
		checkJumps("alu");
	endtask

	initial begin
		controlWordT c;
		dataT w;
		dataT vals [8];
		dataT pcWant;
		int waitCount;
		dataT specA [4] = '{16'h7fff, 16'h8000, 16'h7fff, 16'h8000};
		dataT specB [4] = '{16'h0001, 16'h8000, 16'hffff, 16'h0001};
		rstN_i = 1'b0;
		ctrl_i = idleWord();
		memReadData_i = '0;
		foreach (mRegs[i]) mRegs[i] = '0;
		{mMar, mMdr, mPc, mT, mIr, mAluOut} = '0;
		mFlags = '0;
		repeat (10) @(posedge Clock);
		@(negedge Clock);
		rstN_i = 1'b1;
		waitCount = 0;
		while (memAddr_o !== 16'd0 && waitCount < 20) begin
			@(negedge Clock);
			waitCount++;
		end
		if (waitCount >= 20) begin
			errors++;
			$display("MAR never settled to zero after reset");
		end
		checkState("reset");
		checkJumps("reset");
		for (int r = 0; r < 8; r++) begin
			w = dataT'(randBits(16));
			writeReg(regNumT'(r), w);
			c = idleWord();
			c.busSrc = busRegFile;
			c.marWrite = 1'b1;
			applyWord(c, 16'd0);
			checkValue("round trip", w, memAddr_o);
			checkState("round trip");
		end
		for (int op = 0; op < 5; op++) begin
			runAlu(aluOpT'(op), dataT'(randBits(16)), dataT'(randBits(16)));
			for (int k = 0; k < 4; k++) runAlu(aluOpT'(op), specA[k], specB[k]);
		end
		// T and PC start near the top so the increments wrap.
		loadMdr(16'hfff6);
		c = idleWord();
		c.busSrc = busMdr;
		c.tWrite = 1'b1;
		applyWord(c, 16'd0);
		c = idleWord();
		c.pcWrite = 1'b1;
		applyWord(c, 16'd0);
		checkValue("pc const0", 16'hfff6, pc_o);
		pcWant = 16'hfff6;
		for (int i = 0; i < 10; i++) begin
			c = idleWord();
			c.busSrc = busPc;
			c.tWrite = 1'b1;
			applyWord(c, 16'd0);
			c = idleWord();
			c.busSrc = busConst2;
			c.pcWrite = 1'b1;
			applyWord(c, 16'd0);
			pcWant = pcWant + 16'd2;
			checkValue("pc increment", pcWant, pc_o);
		end
		for (int r = 0; r < 8; r++) begin
			vals[r] = 16'h1000 + dataT'(r) * 16'h0111;
			writeReg(regNumT'(r), vals[r]);
		end
		for (int n = 0; n < 3; n++) begin
			w = dataT'(randBits(16));
			loadIr(w);
			for (int f = 0; f < 3; f++) begin
				c = idleWord();
				c.busSrc = busRegFile;
				c.regNumSrc = regNumSrcT'(f);
				c.marWrite = 1'b1;
				applyWord(c, 16'd0);
				checkValue("ir field", vals[(w >> (9 - 3 * f)) & 16'h7], memAddr_o);
				checkState("ir field");
			end
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
